//--- design/gb_pkg.sv
// ----------------------------------------------------------------------
// Global buffer package
// Bank geometry, interface data-type codes and the shared types of the
// activation global buffer
// ----------------------------------------------------------------------
`default_nettype none

package gb_pkg;

    localparam int BANK_CNT    = 8;
    localparam int BANK_DEPTH  = 64;
    localparam int BANK_ADDR_W = 6;
    localparam int BANK_SEL_W  = 3;
    localparam int WORD_W      = 128;
    localparam int FLG_W       = 32;
    localparam int FLG_LANES   = 4;
    localparam int WCNT_W      = 10;   // Covers the whole pool of 512 words
    localparam int DT_W        = 3;

    localparam logic [DT_W-1:0] DT_ACT    = 3'd2;
    localparam logic [DT_W-1:0] DT_ACTFLG = 3'd3;

    // Layer configuration
    typedef struct packed {
        logic [3:0]        act_banks;
        logic [3:0]        flg_banks;
        logic [WCNT_W-1:0] act_words;
        logic [WCNT_W-1:0] flg_words;
    } gb_cfg_t;

    typedef struct packed {
        logic [BANK_SEL_W-1:0] base_bank;
        logic [WCNT_W-1:0]     words;
    } gb_region_t;

    typedef struct packed {
        logic                   en;
        logic [BANK_SEL_W-1:0]  bank;
        logic [BANK_ADDR_W-1:0] addr;
        logic [WORD_W-1:0]      data;
    } bank_wr_t;

    typedef struct packed {
        logic                   en;
        logic [BANK_SEL_W-1:0]  bank;
        logic [BANK_ADDR_W-1:0] addr;
    } bank_rd_t;

    // Stored word with lane 0 in the low bits
    typedef union packed {
        logic [WORD_W-1:0]                 raw;
        logic [FLG_LANES-1:0][FLG_W-1:0]   lane;
    } gb_word_u;

endpackage

`default_nettype wire

//--- design/gb_cfg_ctrl.sv
// ----------------------------------------------------------------------
// Global buffer layer configuration
// Accepts one configuration per layer, derives the activation and flag
// regions and waits for both readers before taking the next one
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gb_cfg_ctrl (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               cfg_val_i,
    input  wire gb_pkg::gb_cfg_t    cfg_i,
    input  wire logic               act_rd_done_i,
    input  wire logic               flg_rd_done_i,
    output logic                    cfg_rdy_o,
    output logic                    start_o,
    output gb_pkg::gb_region_t      act_region_o,
    output gb_pkg::gb_region_t      flg_region_o
);

    gb_pkg::gb_cfg_t cfg_q;
    logic            busy_q;
    logic            act_done_q;
    logic            flg_done_q;
    logic            accept;
    logic            act_seen;
    logic            flg_seen;

    assign accept   = cfg_val_i && cfg_rdy_o;
    assign act_seen = act_done_q || act_rd_done_i;
    assign flg_seen = flg_done_q || flg_rd_done_i;

    always_ff @(posedge clk) begin
        if (accept) cfg_q <= cfg_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_rdy_o  <= 1'b0;
            start_o    <= 1'b0;
            busy_q     <= 1'b0;
            act_done_q <= 1'b0;
            flg_done_q <= 1'b0;
        end else begin
            start_o <= accept;
            if (accept) begin
                cfg_rdy_o  <= 1'b0;
                busy_q     <= 1'b1;
                act_done_q <= 1'b0;
                flg_done_q <= 1'b0;
            end else if (busy_q) begin
                act_done_q <= act_seen;
                flg_done_q <= flg_seen;
                if (act_seen && flg_seen) begin
                    busy_q    <= 1'b0;
                    cfg_rdy_o <= 1'b1;
                end
            end else begin
                cfg_rdy_o <= 1'b1;   // Idle after reset
            end
        end
    end

    // Activations start at bank 0 and flags follow them
    assign act_region_o.base_bank = '0;
    assign act_region_o.words     = cfg_q.act_words;
    assign flg_region_o.base_bank = cfg_q.act_banks[gb_pkg::BANK_SEL_W-1:0];
    assign flg_region_o.words     = cfg_q.flg_words;

endmodule

`default_nettype wire

//--- design/gb_write_ctrl.sv
// ----------------------------------------------------------------------
// Global buffer write controller
// Requests activation then flag words from the interface and writes
// them to consecutive bank addresses of their region
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gb_write_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       start_i,
    input  wire gb_pkg::gb_region_t         act_region_i,
    input  wire gb_pkg::gb_region_t         flg_region_i,
    input  wire logic                       if_conf_rdy_i,
    output logic                            if_conf_val_o,
    output logic [gb_pkg::DT_W-1:0]         if_conf_dt_o,
    input  wire logic                       if_data_val_i,
    input  wire logic [gb_pkg::WORD_W-1:0]  if_data_i,
    output logic                            if_data_rdy_o,
    output gb_pkg::bank_wr_t                bank_wr_o,
    output logic                            act_wr_done_o,
    output logic                            flg_wr_done_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACT_REQ,
        ST_ACT_DATA,
        ST_FLG_REQ,
        ST_FLG_DATA
    } wr_state_e;

    wr_state_e                      state_q;
    logic [gb_pkg::WCNT_W-1:0]      cnt_q;
    logic [gb_pkg::BANK_SEL_W-1:0]  bank_q;
    logic [gb_pkg::BANK_ADDR_W-1:0] addr_q;
    gb_pkg::gb_region_t             cur_region;
    logic                           flg_phase;
    logic                           conf_acc;
    logic                           wr_acc;
    logic                           last_wr;

    assign flg_phase  = (state_q == ST_FLG_REQ) || (state_q == ST_FLG_DATA);
    assign cur_region = flg_phase ? flg_region_i : act_region_i;

    assign if_conf_val_o = (state_q == ST_ACT_REQ) || (state_q == ST_FLG_REQ);
    assign if_conf_dt_o  = flg_phase ? gb_pkg::DT_ACTFLG : gb_pkg::DT_ACT;
    assign if_data_rdy_o = (state_q == ST_ACT_DATA) || (state_q == ST_FLG_DATA);

    assign conf_acc = if_conf_val_o && if_conf_rdy_i;
    assign wr_acc   = if_data_rdy_o && if_data_val_i;
    assign last_wr  = wr_acc && (cnt_q == cur_region.words - 1'b1);

    // Accepted word goes straight to the banks
    assign bank_wr_o.en   = wr_acc;
    assign bank_wr_o.bank = bank_q;
    assign bank_wr_o.addr = addr_q;
    assign bank_wr_o.data = if_data_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= ST_IDLE;
            cnt_q         <= '0;
            bank_q        <= '0;
            addr_q        <= '0;
            act_wr_done_o <= 1'b0;
            flg_wr_done_o <= 1'b0;
        end else begin
            act_wr_done_o <= last_wr && !flg_phase;
            flg_wr_done_o <= last_wr && flg_phase;

            if (conf_acc) begin
                cnt_q  <= '0;
                bank_q <= cur_region.base_bank;
                addr_q <= '0;
            end else if (wr_acc) begin
                cnt_q  <= cnt_q + 1'b1;
                addr_q <= addr_q + 1'b1;
                if (addr_q == gb_pkg::BANK_ADDR_W'(gb_pkg::BANK_DEPTH - 1))
                    bank_q <= bank_q + 1'b1;   // Spill into next bank
            end

            case (state_q)
                ST_IDLE:     if (start_i)  state_q <= ST_ACT_REQ;
                ST_ACT_REQ:  if (conf_acc) state_q <= ST_ACT_DATA;
                ST_ACT_DATA: if (last_wr)  state_q <= ST_FLG_REQ;
                ST_FLG_REQ:  if (conf_acc) state_q <= ST_FLG_DATA;
                ST_FLG_DATA: if (last_wr)  state_q <= ST_IDLE;
                default:                   state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/gb_bank_array.sv
// ----------------------------------------------------------------------
// Global buffer bank array
// SRAM banks with one shared write port and a read port per reader
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gb_bank_array (
    input  wire logic               clk,
    input  wire gb_pkg::bank_wr_t   bank_wr_i,
    input  wire gb_pkg::bank_rd_t   act_rd_i,
    input  wire gb_pkg::bank_rd_t   flg_rd_i,
    output gb_pkg::gb_word_u        act_word_o,
    output gb_pkg::gb_word_u        flg_word_o
);

    logic [gb_pkg::WORD_W-1:0]      rd_q [gb_pkg::BANK_CNT];
    logic [gb_pkg::BANK_SEL_W-1:0]  act_sel_q;
    logic [gb_pkg::BANK_SEL_W-1:0]  flg_sel_q;

    for (genvar b = 0; b < gb_pkg::BANK_CNT; b++) begin : g_bank
        logic [gb_pkg::WORD_W-1:0]      mem [gb_pkg::BANK_DEPTH];
        logic [gb_pkg::WORD_W-1:0]      rd_word;
        logic [gb_pkg::BANK_ADDR_W-1:0] rd_addr;
        logic                           wr_hit;
        logic                           act_hit;
        logic                           flg_hit;

        assign wr_hit  = bank_wr_i.en && (bank_wr_i.bank == gb_pkg::BANK_SEL_W'(b));
        assign act_hit = act_rd_i.en && (act_rd_i.bank == gb_pkg::BANK_SEL_W'(b));
        assign flg_hit = flg_rd_i.en && (flg_rd_i.bank == gb_pkg::BANK_SEL_W'(b));

        // Regions are disjoint, so at most one reader hits
        assign rd_addr = act_hit ? act_rd_i.addr : flg_rd_i.addr;

        always_ff @(posedge clk) begin
            if (wr_hit) mem[bank_wr_i.addr] <= bank_wr_i.data;
            if (act_hit || flg_hit) rd_word <= mem[rd_addr];
        end

        assign rd_q[b] = rd_word;
    end

    // Remember which bank each reader addressed
    always_ff @(posedge clk) begin
        if (act_rd_i.en) act_sel_q <= act_rd_i.bank;
        if (flg_rd_i.en) flg_sel_q <= flg_rd_i.bank;
    end

    assign act_word_o.raw = rd_q[act_sel_q];
    assign flg_word_o.raw = rd_q[flg_sel_q];

endmodule

`default_nettype wire

//--- design/gb_stream_reader.sv
// ----------------------------------------------------------------------
// Global buffer stream reader
// Walks one region in write order and streams it out through a
// one-word buffer, either whole words or one lane at a time
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gb_stream_reader #(
    parameter int LANES = 1
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire gb_pkg::gb_region_t                 region_i,
    input  wire logic                               wr_done_i,
    output gb_pkg::bank_rd_t                        rd_o,
    input  wire gb_pkg::gb_word_u                   word_i,
    output logic                                    out_val_o,
    output logic [gb_pkg::WORD_W/LANES-1:0]         out_data_o,
    input  wire logic                               out_rdy_i,
    output logic                                    rd_done_o
);

    logic                                   active_q;
    logic                                   inflight_q;
    logic [gb_pkg::WCNT_W-1:0]              rd_cnt_q;
    logic [gb_pkg::WCNT_W-1:0]              out_cnt_q;
    logic [gb_pkg::BANK_SEL_W-1:0]          bank_q;
    logic [gb_pkg::BANK_ADDR_W-1:0]         addr_q;
    logic [$clog2(gb_pkg::FLG_LANES)-1:0]   lane_q;
    gb_pkg::gb_word_u                       buf_q;
    logic                                   pop;
    logic                                   pop_word;
    logic                                   issue;

    assign pop      = out_val_o && out_rdy_i;
    assign pop_word = pop && (lane_q == LANES - 1);

    // Only read when the buffer is free by the time the data lands
    assign issue = active_q && !inflight_q && (!out_val_o || pop_word);

    assign rd_o.en   = issue;
    assign rd_o.bank = bank_q;
    assign rd_o.addr = addr_q;

    //----------------------------------------------------------------------
    // Read address walk
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q   <= 1'b0;
            inflight_q <= 1'b0;
            rd_cnt_q   <= '0;
            bank_q     <= '0;
            addr_q     <= '0;
        end else begin
            inflight_q <= issue;
            if (wr_done_i) begin
                active_q <= 1'b1;
                rd_cnt_q <= '0;
                bank_q   <= region_i.base_bank;
                addr_q   <= '0;
            end else if (issue) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
                addr_q   <= addr_q + 1'b1;
                if (addr_q == gb_pkg::BANK_ADDR_W'(gb_pkg::BANK_DEPTH - 1))
                    bank_q <= bank_q + 1'b1;
                if (rd_cnt_q == region_i.words - 1'b1)
                    active_q <= 1'b0;   // Last read issued
            end
        end
    end

    //----------------------------------------------------------------------
    // Output buffer and lane walk
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (inflight_q) buf_q <= word_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_val_o <= 1'b0;
            lane_q    <= '0;
            out_cnt_q <= '0;
            rd_done_o <= 1'b0;
        end else begin
            rd_done_o <= pop_word && (out_cnt_q == region_i.words - 1'b1);
            if (inflight_q)
                out_val_o <= 1'b1;
            else if (pop_word)
                out_val_o <= 1'b0;

            if (wr_done_i)
                out_cnt_q <= '0;
            else if (pop_word)
                out_cnt_q <= out_cnt_q + 1'b1;

            if (pop_word)
                lane_q <= '0;
            else if (pop)
                lane_q <= lane_q + 1'b1;
        end
    end

    if (LANES == 1) begin : g_word
        assign out_data_o = buf_q.raw;
    end else begin : g_lane
        assign out_data_o = buf_q.lane[lane_q];   // Lane 0 first
    end

endmodule

`default_nettype wire

//--- design/gb_top.sv
// ----------------------------------------------------------------------
// Activation global buffer top level
// Configuration, interface write path, banks and the two output streams
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gb_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       cfg_val_i,
    input  wire gb_pkg::gb_cfg_t            cfg_i,
    output logic                            cfg_rdy_o,
    output logic                            if_conf_val_o,
    output logic [gb_pkg::DT_W-1:0]         if_conf_dt_o,
    input  wire logic                       if_conf_rdy_i,
    input  wire logic                       if_data_val_i,
    input  wire logic [gb_pkg::WORD_W-1:0]  if_data_i,
    output logic                            if_data_rdy_o,
    output logic                            act_val_o,
    output logic [gb_pkg::WORD_W-1:0]       act_data_o,
    input  wire logic                       act_rdy_i,
    output logic                            flg_val_o,
    output logic [gb_pkg::FLG_W-1:0]        flg_data_o,
    input  wire logic                       flg_rdy_i
);

    logic               start;
    gb_pkg::gb_region_t act_region;
    gb_pkg::gb_region_t flg_region;
    gb_pkg::bank_wr_t   bank_wr;
    gb_pkg::bank_rd_t   act_rd;
    gb_pkg::bank_rd_t   flg_rd;
    gb_pkg::gb_word_u   act_word;
    gb_pkg::gb_word_u   flg_word;
    logic               act_wr_done;
    logic               flg_wr_done;
    logic               act_rd_done;
    logic               flg_rd_done;

    gb_cfg_ctrl cfg_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_val_i     (cfg_val_i),
        .cfg_i         (cfg_i),
        .act_rd_done_i (act_rd_done),
        .flg_rd_done_i (flg_rd_done),
        .cfg_rdy_o     (cfg_rdy_o),
        .start_o       (start),
        .act_region_o  (act_region),
        .flg_region_o  (flg_region)
    );

    gb_write_ctrl write_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start),
        .act_region_i  (act_region),
        .flg_region_i  (flg_region),
        .if_conf_rdy_i (if_conf_rdy_i),
        .if_conf_val_o (if_conf_val_o),
        .if_conf_dt_o  (if_conf_dt_o),
        .if_data_val_i (if_data_val_i),
        .if_data_i     (if_data_i),
        .if_data_rdy_o (if_data_rdy_o),
        .bank_wr_o     (bank_wr),
        .act_wr_done_o (act_wr_done),
        .flg_wr_done_o (flg_wr_done)
    );

    gb_bank_array bank_array_i (
        .clk        (clk),
        .bank_wr_i  (bank_wr),
        .act_rd_i   (act_rd),
        .flg_rd_i   (flg_rd),
        .act_word_o (act_word),
        .flg_word_o (flg_word)
    );

    gb_stream_reader #(.LANES(1)) act_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .region_i   (act_region),
        .wr_done_i  (act_wr_done),
        .rd_o       (act_rd),
        .word_i     (act_word),
        .out_val_o  (act_val_o),
        .out_data_o (act_data_o),
        .out_rdy_i  (act_rdy_i),
        .rd_done_o  (act_rd_done)
    );

    gb_stream_reader #(.LANES(gb_pkg::FLG_LANES)) flg_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .region_i   (flg_region),
        .wr_done_i  (flg_wr_done),
        .rd_o       (flg_rd),
        .word_i     (flg_word),
        .out_val_o  (flg_val_o),
        .out_data_o (flg_data_o),
        .out_rdy_i  (flg_rdy_i),
        .rd_done_o  (flg_rd_done)
    );

endmodule

`default_nettype wire

//--- sim/gb_tb.sv
// ----------------------------------------------------------------------
// Activation global buffer testbench
// Table-driven layers with an interface model and checks on both streams
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gb_tb;

    localparam int ROWS        = 5;
    localparam int SEED        = 54524;
    localparam int ITEM_LIMIT  = 4000;    // Cycles allowed between two events
    localparam int LAYER_LIMIT = 20000;

    typedef struct packed {
        logic [3:0] act_banks;
        logic [3:0] flg_banks;
        logic [9:0] act_words;
        logic [9:0] flg_words;
        logic [3:0] conf_dly;
        logic [6:0] act_drop;   // Percent of cycles with rdy low
        logic [6:0] flg_drop;
    } row_t;

    logic                           clk;
    logic                           rst_n;
    logic                           cfg_val_i;
    gb_pkg::gb_cfg_t                cfg_i;
    logic                           cfg_rdy_o;
    logic                           if_conf_val_o;
    logic [gb_pkg::DT_W-1:0]        if_conf_dt_o;
    logic                           if_conf_rdy_i;
    logic                           if_data_val_i;
    logic [gb_pkg::WORD_W-1:0]      if_data_i;
    logic                           if_data_rdy_o;
    logic                           act_val_o;
    logic [gb_pkg::WORD_W-1:0]      act_data_o;
    logic                           act_rdy_i;
    logic                           flg_val_o;
    logic [gb_pkg::FLG_W-1:0]       flg_data_o;
    logic                           flg_rdy_i;

    row_t                           table_q [ROWS];
    logic [gb_pkg::WORD_W-1:0]      act_exp [$];
    logic [gb_pkg::WORD_W-1:0]      flg_exp [$];
    int                             act_got;
    int                             flg_got;
    int                             err_cnt;
    int                             to_cnt;

    gb_top dut_i (.*);

    always #4 clk = ~clk;

    task automatic load_table();
        // act_banks flg_banks act_words flg_words conf_dly act_drop flg_drop
        table_q[0] = '{4'd1, 4'd1, 10'd5,   10'd3,   4'd0, 7'd0,  7'd0};
        table_q[1] = '{4'd2, 4'd1, 10'd100, 10'd40,  4'd2, 7'd30, 7'd30};
        table_q[2] = '{4'd4, 4'd4, 10'd256, 10'd200, 4'd1, 7'd20, 7'd50};
        table_q[3] = '{4'd3, 4'd2, 10'd150, 10'd70,  4'd3, 7'd50, 7'd20};
        table_q[4] = '{4'd6, 4'd2, 10'd321, 10'd65,  4'd0, 7'd40, 7'd40};
    endtask

    task automatic report_mismatch(input string sig, input logic [gb_pkg::WORD_W-1:0] exp,
                                   input logic [gb_pkg::WORD_W-1:0] got);
        $display("ERR t=%0t %s expected %h got %h", $time, sig, exp, got);
        err_cnt++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        to_cnt++;
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Item n of a stream as the interface supplied it
    function automatic logic [gb_pkg::WORD_W-1:0] expected_item(input bit is_flg, input int n);
        logic [gb_pkg::WORD_W-1:0] w;
        w = '0;
        if (!is_flg) begin
            if (n < act_exp.size()) w = act_exp[n];
        end else if (n / gb_pkg::FLG_LANES < flg_exp.size()) begin
            w = flg_exp[n / gb_pkg::FLG_LANES];
            w = gb_pkg::WORD_W'(w[gb_pkg::FLG_W * (n % gb_pkg::FLG_LANES) +: gb_pkg::FLG_W]);
        end
        return w;
    endfunction

    task automatic send_cfg(input row_t r);
        int t;
        t = 0;
        while (!cfg_rdy_o && t < ITEM_LIMIT) begin
            next_cycle();
            t++;
        end
        if (!cfg_rdy_o) begin
            report_failure("cfg_rdy_o never rose");
            return;
        end
        cfg_val_i           = 1'b1;
        cfg_i.act_banks     = r.act_banks;
        cfg_i.flg_banks     = r.flg_banks;
        cfg_i.act_words     = r.act_words;
        cfg_i.flg_words     = r.flg_words;
        next_cycle();
        cfg_val_i = 1'b0;
        assert (!cfg_rdy_o) else report_mismatch("cfg_rdy_o", '0, gb_pkg::WORD_W'(cfg_rdy_o));
    endtask

    task automatic serve_phase(input logic [gb_pkg::DT_W-1:0] dt, input int words,
                               input int dly, input bit is_flg, output bit ok);
        int                         n;
        int                         t;
        logic [gb_pkg::WORD_W-1:0]  w;
        ok = 1'b0;
        t  = 0;
        while (!if_conf_val_o && t < ITEM_LIMIT) begin
            next_cycle();
            t++;
        end
        if (!if_conf_val_o) begin
            report_failure("no conf request from the DUT");
            return;
        end
        assert (if_conf_dt_o == dt)
            else report_mismatch("if_conf_dt_o", gb_pkg::WORD_W'(dt),
                                 gb_pkg::WORD_W'(if_conf_dt_o));
        repeat (dly) begin
            next_cycle();
            assert (if_conf_val_o && if_conf_dt_o == dt)
                else report_failure("conf request changed before its handshake");
        end
        if_conf_rdy_i = 1'b1;
        next_cycle();
        if_conf_rdy_i = 1'b0;

        n = 0;
        t = 0;
        while (n < words && t < ITEM_LIMIT) begin
            w             = {$urandom, $urandom, $urandom, $urandom};
            if_data_val_i = ($urandom % 4) != 0;   // Some idle cycles
            if_data_i     = w;
            if (if_data_val_i && if_data_rdy_o) begin
                if (is_flg) flg_exp.push_back(w);
                else act_exp.push_back(w);
                n++;
                t = 0;
            end else begin
                t++;
            end
            next_cycle();
        end
        if_data_val_i = 1'b0;
        if (n < words) begin
            report_failure("interface data phase stalled");
            return;
        end
        assert (!if_data_rdy_o)
            else report_mismatch("if_data_rdy_o", '0, gb_pkg::WORD_W'(if_data_rdy_o));
        ok = 1'b1;
    endtask

    task automatic serve_interface(input row_t r);
        bit ok;
        serve_phase(gb_pkg::DT_ACT, int'(r.act_words), int'(r.conf_dly), 1'b0, ok);
        if (ok) serve_phase(gb_pkg::DT_ACTFLG, int'(r.flg_words), int'(r.conf_dly), 1'b1, ok);
    endtask

    task automatic check_stream(input bit is_flg, input int items, input int drop);
        int                         n;
        int                         t;
        bit                         held;
        bit                         val;
        bit                         rdy;
        logic [gb_pkg::WORD_W-1:0]  got;
        logic [gb_pkg::WORD_W-1:0]  held_data;
        logic [gb_pkg::WORD_W-1:0]  exp;
        string                      sig;
        n         = 0;
        t         = 0;
        held      = 1'b0;
        held_data = '0;
        sig       = is_flg ? "flg_data_o" : "act_data_o";
        while (n < items && t < ITEM_LIMIT) begin
            val = is_flg ? flg_val_o : act_val_o;
            got = is_flg ? gb_pkg::WORD_W'(flg_data_o) : act_data_o;
            if (held) begin   // Stalled item must stay put
                assert (val) else report_failure({sig, " lost val while rdy was low"});
                assert (got == held_data) else report_mismatch(sig, held_data, got);
            end
            rdy = ($urandom % 100) >= drop;
            if (is_flg) flg_rdy_i = rdy;
            else act_rdy_i = rdy;
            held      = val && !rdy;
            held_data = got;
            if (val && rdy) begin
                exp = expected_item(is_flg, n);
                assert (got == exp) else report_mismatch(sig, exp, got);
                n++;
                t = 0;
                if (is_flg) flg_got = n;
                else act_got = n;
            end else begin
                t++;
            end
            next_cycle();
        end
        if (is_flg) flg_rdy_i = 1'b0;
        else act_rdy_i = 1'b0;
        if (n < items) report_failure({sig, " stream stalled before its last item"});
    endtask

    task automatic watch_cfg(input row_t r);
        int t;
        t = 0;
        while (!cfg_rdy_o && t < LAYER_LIMIT) begin
            next_cycle();
            t++;
        end
        if (!cfg_rdy_o) begin
            report_failure("cfg_rdy_o did not return after the layer");
            return;
        end
        assert (act_got == int'(r.act_words) && flg_got == int'(r.flg_words) * 4)
            else report_failure("cfg_rdy_o rose before both streams finished");
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial begin
        row_t row;
        int   row_err;
        int   rows_run;
        int   rows_failed;
        clk           = 1'b0;
        rst_n         = 1'b0;
        cfg_val_i     = 1'b0;
        cfg_i         = '0;
        if_conf_rdy_i = 1'b0;
        if_data_val_i = 1'b0;
        if_data_i     = '0;
        act_rdy_i     = 1'b0;
        flg_rdy_i     = 1'b0;
        err_cnt       = 0;
        to_cnt        = 0;
        rows_run      = 0;
        rows_failed   = 0;
        void'($urandom(SEED));
        load_table();

        repeat (2) @(posedge clk);
        #1;
        assert (!cfg_rdy_o && !if_conf_val_o && !if_data_rdy_o && !act_val_o && !flg_val_o)
            else report_failure("a val or rdy output was high during reset");
        rst_n = 1'b1;

        for (int r = 0; r < ROWS; r++) begin
            row     = table_q[r];
            row_err = err_cnt + to_cnt;
            act_got = 0;
            flg_got = 0;
            act_exp.delete();
            flg_exp.delete();
            send_cfg(row);
            if (to_cnt == 0) begin
                fork
                    serve_interface(row);
                    check_stream(1'b0, int'(row.act_words), int'(row.act_drop));
                    check_stream(1'b1, int'(row.flg_words) * 4, int'(row.flg_drop));
                    watch_cfg(row);
                join
            end
            assert (!act_val_o && !flg_val_o)
                else report_failure("a stream still holds an item after the layer");
            rows_run++;
            if (err_cnt + to_cnt != row_err) rows_failed++;
            $display("row %0d: act %0d words in %0d banks, flg %0d words in %0d banks, %s",
                     r, row.act_words, row.act_banks, row.flg_words, row.flg_banks,
                     (err_cnt + to_cnt == row_err) ? "ok" : "failed");
            if (to_cnt != 0) break;
        end

        $display("rows run %0d, rows failed %0d, value errors %0d, other failures %0d",
                 rows_run, rows_failed, err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/gb_pkg.sv
design/gb_cfg_ctrl.sv
design/gb_write_ctrl.sv
design/gb_bank_array.sv
design/gb_stream_reader.sv
design/gb_top.sv
sim/gb_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the global buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 -f build.f --top-module gb_tb -o gb_sim \
    > build.log 2>&1 &&
./obj_dir/gb_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "TEST PASS" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
